//--- common/rn_arch_pkg.sv
package rn_arch_pkg;

  // dispatch group width
  localparam int DISP_SIZE = 2;

  // integer register file only
  localparam int ARCH_REG_NUM = 32;

  localparam int ARCH_REG_W = $clog2(ARCH_REG_NUM);

  // architectural register index, x0 .. x31
  typedef logic [ARCH_REG_W-1:0] arch_reg_t;

  // one bit per dispatch lane
  typedef logic [DISP_SIZE-1:0] lane_mask_t;

endpackage

//--- common/rn_phys_pkg.sv
package rn_phys_pkg;

  // entries per lane free list
  localparam int FLIST_SIZE = 16;

  // identity-mapped ids plus every free list entry
  localparam int RNID_SIZE = rn_arch_pkg::ARCH_REG_NUM + rn_arch_pkg::DISP_SIZE * FLIST_SIZE;

  localparam int RNID_W = $clog2(RNID_SIZE);

  // physical register id
  typedef logic [RNID_W-1:0] rnid_t;

  // index bits plus one wrap bit on top
  typedef logic [$clog2(FLIST_SIZE):0] flist_ptr_t;

endpackage

//--- common/rn_alloc_if.sv
`timescale 1ns/1ns

interface rn_alloc_if;
  import rn_arch_pkg::*;
  import rn_phys_pkg::*;

  lane_mask_t                 pop;     // take the head id of this lane
  rnid_t      [DISP_SIZE-1:0] pop_id;  // head of each lane's list
  lane_mask_t                 empty;

  modport bank (
    input  pop,
    output pop_id,
    output empty
  );

  modport merge (
    output pop,
    input  pop_id,
    input  empty
  );

endinterface

//--- common/rn_lookup_if.sv
`timescale 1ns/1ns

interface rn_lookup_if;
  import rn_arch_pkg::*;
  import rn_phys_pkg::*;

  // source lookups, index 0 is rs1 and index 1 is rs2
  arch_reg_t  [DISP_SIZE-1:0][1:0] src_arch;
  rnid_t      [DISP_SIZE-1:0][1:0] src_rnid;

  arch_reg_t  [DISP_SIZE-1:0] rd_arch;
  rnid_t      [DISP_SIZE-1:0] rd_old_rnid;  // mapping before this group

  lane_mask_t                 upd_valid;
  arch_reg_t  [DISP_SIZE-1:0] upd_arch;
  rnid_t      [DISP_SIZE-1:0] upd_rnid;

  modport tbl (
    input  src_arch,
    output src_rnid,
    input  rd_arch,
    output rd_old_rnid,
    input  upd_valid,
    input  upd_arch,
    input  upd_rnid
  );

  modport merge (
    output src_arch,
    input  src_rnid,
    output rd_arch,
    input  rd_old_rnid,
    output upd_valid,
    output upd_arch,
    output upd_rnid
  );

endinterface

//--- rn_freelist_bank/rn_freelist.sv
`timescale 1ns/1ns

module rn_freelist #(
  parameter int SIZE      = rn_phys_pkg::FLIST_SIZE,
  parameter int INIT_BASE = rn_arch_pkg::ARCH_REG_NUM
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_push,
  input  rn_phys_pkg::rnid_t i_push_id,
  input  logic               i_pop,
  output rn_phys_pkg::rnid_t o_pop_id,
  output logic               o_empty
);
  import rn_phys_pkg::*;

  localparam int IDX_W = $bits(flist_ptr_t) - 1;

  rnid_t      r_list [SIZE];
  flist_ptr_t r_head;
  flist_ptr_t r_tail;

  // step a pointer, flipping the wrap bit past the last entry
  function automatic flist_ptr_t ptr_next(input flist_ptr_t ptr);
    flist_ptr_t nxt;
    if (ptr[IDX_W-1:0] == IDX_W'(SIZE - 1)) begin
      nxt = {~ptr[IDX_W], {IDX_W{1'b0}}};
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_tail <= {1'b1, {IDX_W{1'b0}}};  // full, wrap bits differ
      for (int i = 0; i < SIZE; i++) begin
        r_list[i] <= rnid_t'(INIT_BASE + i);  // ascending ids
      end
    end else begin
      if (i_push) begin
        r_list[r_tail[IDX_W-1:0]] <= i_push_id;
        r_tail                    <= ptr_next(r_tail);
      end
      if (i_pop) begin
        r_head <= ptr_next(r_head);
      end
    end
  end

  assign o_pop_id = r_list[r_head[IDX_W-1:0]];  // head always visible
  assign o_empty  = (r_head == r_tail);

endmodule

//--- rn_freelist_bank/rn_freelist_bank.sv
`timescale 1ns/1ns

module rn_freelist_bank (
  input  logic                                                 i_clk,
  input  logic                                                 i_reset_n,
  input  logic                                                 i_commit_valid,
  input  rn_arch_pkg::lane_mask_t                              i_commit_lane,
  input  rn_arch_pkg::lane_mask_t                              i_commit_dead,
  input  rn_arch_pkg::arch_reg_t [rn_arch_pkg::DISP_SIZE-1:0] i_commit_rd_arch,
  input  rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] i_commit_rd_rnid,
  input  rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] i_commit_old_rnid,
  rn_alloc_if.bank                                             alloc
);
  import rn_arch_pkg::*;
  import rn_phys_pkg::*;

  logic                       r_commit_valid;
  lane_mask_t                 r_commit_lane;
  lane_mask_t                 r_commit_dead;
  arch_reg_t  [DISP_SIZE-1:0] r_commit_rd_arch;
  rnid_t      [DISP_SIZE-1:0] r_commit_rd_rnid;
  rnid_t      [DISP_SIZE-1:0] r_commit_old_rnid;

  // commit info lands here first, the push follows one edge later
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_commit_valid <= 1'b0;
      r_commit_lane  <= '0;
    end else begin
      r_commit_valid <= i_commit_valid;
      r_commit_lane  <= i_commit_lane;
    end
  end

  always_ff @(posedge i_clk) begin
    r_commit_dead     <= i_commit_dead;
    r_commit_rd_arch  <= i_commit_rd_arch;
    r_commit_rd_rnid  <= i_commit_rd_rnid;
    r_commit_old_rnid <= i_commit_old_rnid;
  end

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lane
    logic  w_push;
    rnid_t w_push_id;
    rnid_t w_pop_id;
    logic  w_empty;

    // x0 never allocated, so nothing to give back
    assign w_push = r_commit_valid & r_commit_lane[d] & (r_commit_rd_arch[d] != '0);

    // dead: its own new id is garbage, otherwise the overwritten mapping is
    assign w_push_id = r_commit_dead[d] ? r_commit_rd_rnid[d] : r_commit_old_rnid[d];

    rn_freelist #(
      .SIZE      (FLIST_SIZE),
      .INIT_BASE (ARCH_REG_NUM + FLIST_SIZE * d)
    ) u_freelist (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_push    (w_push),
      .i_push_id (w_push_id),
      .i_pop     (alloc.pop[d]),
      .o_pop_id  (w_pop_id),
      .o_empty   (w_empty)
    );

    assign alloc.pop_id[d] = w_pop_id;
    assign alloc.empty[d]  = w_empty;
  end

endmodule

//--- rn_map_table/rn_map_table.sv
`timescale 1ns/1ns

module rn_map_table (
  input  logic    i_clk,
  input  logic    i_reset_n,
  rn_lookup_if.tbl lookup
);
  import rn_arch_pkg::*;
  import rn_phys_pkg::*;

  rnid_t r_map [ARCH_REG_NUM];

  // reads see the map before this cycle's updates
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_read
    for (genvar s = 0; s < 2; s++) begin : g_src
      assign lookup.src_rnid[d][s] = r_map[lookup.src_arch[d][s]];
    end
    assign lookup.rd_old_rnid[d] = r_map[lookup.rd_arch[d]];
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        r_map[r] <= rnid_t'(r);  // identity, x0 -> 0
      end
    end else begin
      // ascending lane order so the younger write lands last
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (lookup.upd_valid[d] && (lookup.upd_arch[d] != '0)) begin
          r_map[lookup.upd_arch[d]] <= lookup.upd_rnid[d];
        end
      end
    end
  end

endmodule

//--- src/rn_dispatch_merge.sv
`timescale 1ns/1ns

module rn_dispatch_merge (
  input  logic                                                 i_clk,
  input  logic                                                 i_reset_n,
  input  logic                                                 i_in_valid,
  output logic                                                 o_in_ready,
  input  rn_arch_pkg::lane_mask_t                              i_in_lane_valid,
  input  rn_arch_pkg::lane_mask_t                              i_in_rd_valid,
  input  rn_arch_pkg::arch_reg_t [rn_arch_pkg::DISP_SIZE-1:0] i_in_rd_arch,
  input  rn_arch_pkg::arch_reg_t [rn_arch_pkg::DISP_SIZE-1:0] i_in_rs1_arch,
  input  rn_arch_pkg::arch_reg_t [rn_arch_pkg::DISP_SIZE-1:0] i_in_rs2_arch,
  input  logic                                                 i_resource_ok,
  rn_alloc_if.merge                                            alloc,
  rn_lookup_if.merge                                           lookup,
  output logic                                                 o_out_valid,
  output rn_arch_pkg::lane_mask_t                              o_out_lane_valid,
  output rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] o_out_rd_rnid,
  output rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] o_out_rd_old_rnid,
  output rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] o_out_rs1_rnid,
  output rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] o_out_rs2_rnid
);
  import rn_arch_pkg::*;
  import rn_phys_pkg::*;

  lane_mask_t             w_need_rd;  // lane takes a fresh id
  logic                   w_fire;
  rnid_t  [DISP_SIZE-1:0] w_rd_rnid;
  rnid_t  [DISP_SIZE-1:0] w_rs1_rnid;
  rnid_t  [DISP_SIZE-1:0] w_rs2_rnid;
  rnid_t  [DISP_SIZE-1:0] w_old_rnid;

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lane
    assign w_need_rd[d] = i_in_lane_valid[d] & i_in_rd_valid[d] & (i_in_rd_arch[d] != '0);
    assign w_rd_rnid[d] = w_need_rd[d] ? alloc.pop_id[d] : '0;  // x0 stays at id 0

    assign lookup.src_arch[d][0] = i_in_rs1_arch[d];
    assign lookup.src_arch[d][1] = i_in_rs2_arch[d];
    assign lookup.rd_arch[d]     = i_in_rd_arch[d];
    assign lookup.upd_arch[d]    = i_in_rd_arch[d];
    assign lookup.upd_rnid[d]    = w_rd_rnid[d];
  end

  // hold the group if any lane that needs an id finds its list empty
  assign o_in_ready = i_resource_ok & ~|(w_need_rd & alloc.empty);
  assign w_fire     = i_in_valid & o_in_ready;

  assign alloc.pop        = {DISP_SIZE{w_fire}} & w_need_rd;
  assign lookup.upd_valid = {DISP_SIZE{w_fire}} & w_need_rd;

  // in-group bypass: the map has not seen the earlier lanes yet
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_rs1_rnid[d] = lookup.src_rnid[d][0];
      w_rs2_rnid[d] = lookup.src_rnid[d][1];
      w_old_rnid[d] = lookup.rd_old_rnid[d];
      // walk older lanes in order, the nearest one overrides
      for (int p = 0; p < d; p++) begin
        if (w_need_rd[p] && (i_in_rd_arch[p] == i_in_rs1_arch[d])) begin
          w_rs1_rnid[d] = w_rd_rnid[p];
        end
        if (w_need_rd[p] && (i_in_rd_arch[p] == i_in_rs2_arch[d])) begin
          w_rs2_rnid[d] = w_rd_rnid[p];
        end
        if (w_need_rd[p] && (i_in_rd_arch[p] == i_in_rd_arch[d])) begin
          w_old_rnid[d] = w_rd_rnid[p];  // freed when lane d commits
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_out_valid      <= 1'b0;
      o_out_lane_valid <= '0;
    end else begin
      o_out_valid <= w_fire;  // plain strobe, no back-pressure
      if (w_fire) begin
        o_out_lane_valid <= i_in_lane_valid;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fire) begin
      o_out_rd_rnid     <= w_rd_rnid;
      o_out_rd_old_rnid <= w_old_rnid;
      o_out_rs1_rnid    <= w_rs1_rnid;
      o_out_rs2_rnid    <= w_rs2_rnid;
    end
  end

endmodule

//--- src/rn_rename_top.sv
`timescale 1ns/1ns

module rn_rename_top (
  input  logic                                                 i_clk,
  input  logic                                                 i_reset_n,
  // dispatch group in
  input  logic                                                 i_in_valid,
  output logic                                                 o_in_ready,
  input  rn_arch_pkg::lane_mask_t                              i_in_lane_valid,
  input  rn_arch_pkg::lane_mask_t                              i_in_rd_valid,
  input  rn_arch_pkg::arch_reg_t [rn_arch_pkg::DISP_SIZE-1:0] i_in_rd_arch,
  input  rn_arch_pkg::arch_reg_t [rn_arch_pkg::DISP_SIZE-1:0] i_in_rs1_arch,
  input  rn_arch_pkg::arch_reg_t [rn_arch_pkg::DISP_SIZE-1:0] i_in_rs2_arch,
  input  logic                                                 i_resource_ok,
  // renamed group toward the scheduler
  output logic                                                 o_out_valid,
  output rn_arch_pkg::lane_mask_t                              o_out_lane_valid,
  output rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] o_out_rd_rnid,
  output rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] o_out_rd_old_rnid,
  output rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] o_out_rs1_rnid,
  output rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] o_out_rs2_rnid,
  // commit release
  input  logic                                                 i_commit_valid,
  input  rn_arch_pkg::lane_mask_t                              i_commit_lane,
  input  rn_arch_pkg::lane_mask_t                              i_commit_dead,
  input  rn_arch_pkg::arch_reg_t [rn_arch_pkg::DISP_SIZE-1:0] i_commit_rd_arch,
  input  rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] i_commit_rd_rnid,
  input  rn_phys_pkg::rnid_t     [rn_arch_pkg::DISP_SIZE-1:0] i_commit_old_rnid
);

  rn_alloc_if  alloc_if ();
  rn_lookup_if lookup_if ();

  rn_freelist_bank u_freelist_bank (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_commit_valid    (i_commit_valid),
    .i_commit_lane     (i_commit_lane),
    .i_commit_dead     (i_commit_dead),
    .i_commit_rd_arch  (i_commit_rd_arch),
    .i_commit_rd_rnid  (i_commit_rd_rnid),
    .i_commit_old_rnid (i_commit_old_rnid),
    .alloc             (alloc_if.bank)
  );

  rn_map_table u_map_table (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .lookup    (lookup_if.tbl)
  );

  rn_dispatch_merge u_dispatch_merge (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_in_valid        (i_in_valid),
    .o_in_ready        (o_in_ready),
    .i_in_lane_valid   (i_in_lane_valid),
    .i_in_rd_valid     (i_in_rd_valid),
    .i_in_rd_arch      (i_in_rd_arch),
    .i_in_rs1_arch     (i_in_rs1_arch),
    .i_in_rs2_arch     (i_in_rs2_arch),
    .i_resource_ok     (i_resource_ok),
    .alloc             (alloc_if.merge),
    .lookup            (lookup_if.merge),
    .o_out_valid       (o_out_valid),
    .o_out_lane_valid  (o_out_lane_valid),
    .o_out_rd_rnid     (o_out_rd_rnid),
    .o_out_rd_old_rnid (o_out_rd_old_rnid),
    .o_out_rs1_rnid    (o_out_rs1_rnid),
    .o_out_rs2_rnid    (o_out_rs2_rnid)
  );

endmodule

//--- tb/rn_rename_asserts.sv
`timescale 1ns/1ns

module rn_rename_asserts (
  input logic                    i_clk,
  input logic                    i_reset_n,
  input logic                    i_in_valid,
  input logic                    i_in_ready,
  input logic                    i_out_valid,
  input rn_arch_pkg::lane_mask_t i_pop,
  input rn_arch_pkg::lane_mask_t i_empty
);

  logic w_fire;
  int   fail_cnt = 0;  // failed assertion count

  assign w_fire = i_in_valid & i_in_ready;

  // renamed group appears exactly one edge after the fire
  a_out_after_fire : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_fire |=> i_out_valid)
    else begin
      $error("output strobe missing one cycle after a fire");
      fail_cnt++;
    end

  a_no_stray_out : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !w_fire |=> !i_out_valid)
    else begin
      $error("output strobe without a fire one cycle earlier");
      fail_cnt++;
    end

  a_no_pop_empty : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_pop & i_empty) == '0)
    else begin
      $error("pop issued on an empty free list");
      fail_cnt++;
    end

endmodule

bind rn_rename_top rn_rename_asserts rn_rename_asserts_i (
  .i_clk       (i_clk),
  .i_reset_n   (i_reset_n),
  .i_in_valid  (i_in_valid),
  .i_in_ready  (o_in_ready),
  .i_out_valid (o_out_valid),
  .i_pop       (alloc_if.pop),
  .i_empty     (alloc_if.empty)
);

//--- tb/tb_rename.sv
`timescale 1ns/1ns

module tb_rename;
  import rn_arch_pkg::*;
  import rn_phys_pkg::*;

  localparam int CLK_HALF    = 50;
  localparam int RESET_CYC   = 10;
  localparam int STROBE_WAIT = 8;     // cycles a group may take to fire
  // about 40 groups of one or two cycles each plus a wide margin
  localparam int CYCLE_LIMIT = 2000;

  logic                       i_clk;
  logic                       i_reset_n;
  logic                       i_in_valid;
  logic                       o_in_ready;
  lane_mask_t                 i_in_lane_valid;
  lane_mask_t                 i_in_rd_valid;
  arch_reg_t  [DISP_SIZE-1:0] i_in_rd_arch;
  arch_reg_t  [DISP_SIZE-1:0] i_in_rs1_arch;
  arch_reg_t  [DISP_SIZE-1:0] i_in_rs2_arch;
  logic                       i_resource_ok;
  logic                       o_out_valid;
  lane_mask_t                 o_out_lane_valid;
  rnid_t      [DISP_SIZE-1:0] o_out_rd_rnid;
  rnid_t      [DISP_SIZE-1:0] o_out_rd_old_rnid;
  rnid_t      [DISP_SIZE-1:0] o_out_rs1_rnid;
  rnid_t      [DISP_SIZE-1:0] o_out_rs2_rnid;
  logic                       i_commit_valid;
  lane_mask_t                 i_commit_lane;
  lane_mask_t                 i_commit_dead;
  arch_reg_t  [DISP_SIZE-1:0] i_commit_rd_arch;
  rnid_t      [DISP_SIZE-1:0] i_commit_rd_rnid;
  rnid_t      [DISP_SIZE-1:0] i_commit_old_rnid;

  // reference model state
  rnid_t                  ref_map [ARCH_REG_NUM];
  rnid_t                  free_q0 [$];
  rnid_t                  free_q1 [$];
  rnid_t  [DISP_SIZE-1:0] exp_rd;
  rnid_t  [DISP_SIZE-1:0] exp_old;
  rnid_t  [DISP_SIZE-1:0] exp_rs1;
  rnid_t  [DISP_SIZE-1:0] exp_rs2;
  integer                 seed = 78111;
  int                     mismatch_cnt = 0;
  int                     other_cnt = 0;
  int                     cycle_cnt = 0;
  string                  test_name;
  rnid_t                  last_old0;
  arch_reg_t              last_rd0;

  rn_rename_top rn_rename_top_i (.*);

  always #CLK_HALF i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check(input string what, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      mismatch_cnt++;
      $display("Mismatch %s / %s: expected %0d, actual %0d", test_name, what, exp_val, act_val);
    end
  endtask

  function automatic arch_reg_t pick_reg();
    return arch_reg_t'(1 + ({$random(seed)} % 31));  // never x0
  endfunction

  function automatic rnid_t take_free(input int lane);
    rnid_t id;
    if (lane == 0) begin
      id = free_q0.pop_front();
    end else begin
      id = free_q1.pop_front();
    end
    return id;
  endfunction

  function automatic void release_id(input int lane, input rnid_t id);
    if (lane == 0) begin
      free_q0.push_back(id);
    end else begin
      free_q1.push_back(id);
    end
  endfunction

  task automatic reset_model();
    for (int r = 0; r < ARCH_REG_NUM; r++) begin
      ref_map[r] = rnid_t'(r);
    end
    for (int i = 0; i < FLIST_SIZE; i++) begin
      free_q0.push_back(rnid_t'(ARCH_REG_NUM + i));
      free_q1.push_back(rnid_t'(ARCH_REG_NUM + FLIST_SIZE + i));
    end
  endtask

  task automatic drive_group(input lane_mask_t lv, input lane_mask_t rv,
                             input arch_reg_t rd0, input arch_reg_t rs1_0, input arch_reg_t rs2_0,
                             input arch_reg_t rd1, input arch_reg_t rs1_1, input arch_reg_t rs2_1);
    i_in_valid       = 1'b1;
    i_in_lane_valid  = lv;
    i_in_rd_valid    = rv;
    i_in_rd_arch[0]  = rd0;
    i_in_rs1_arch[0] = rs1_0;
    i_in_rs2_arch[0] = rs2_0;
    i_in_rd_arch[1]  = rd1;
    i_in_rs1_arch[1] = rs1_1;
    i_in_rs2_arch[1] = rs2_1;
  endtask

  // lanes in order against the model map, so forwarding falls out
  task automatic predict_group();
    for (int d = 0; d < DISP_SIZE; d++) begin
      exp_rs1[d] = ref_map[i_in_rs1_arch[d]];
      exp_rs2[d] = ref_map[i_in_rs2_arch[d]];
      exp_old[d] = ref_map[i_in_rd_arch[d]];
      exp_rd[d]  = '0;
      if (i_in_lane_valid[d] && i_in_rd_valid[d] && (i_in_rd_arch[d] != 0)) begin
        exp_rd[d]                = take_free(d);
        ref_map[i_in_rd_arch[d]] = exp_rd[d];
      end
    end
  endtask

  task automatic wait_strobe();
    int waited;
    waited = 0;
    do begin
      @(posedge i_clk);
      @(negedge i_clk);
      waited++;
    end while (!o_out_valid && (waited < STROBE_WAIT));
    i_in_valid = 1'b0;
    if (!o_out_valid) begin
      other_cnt++;
      $display("%s: no output strobe within %0d cycles", test_name, waited);
    end
  endtask

  task automatic check_group();
    check("lane valid", 32'(i_in_lane_valid), 32'(o_out_lane_valid));
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (i_in_lane_valid[d]) begin
        check($sformatf("rd lane%0d", d), 32'(exp_rd[d]), 32'(o_out_rd_rnid[d]));
        check($sformatf("old lane%0d", d), 32'(exp_old[d]), 32'(o_out_rd_old_rnid[d]));
        check($sformatf("rs1 lane%0d", d), 32'(exp_rs1[d]), 32'(o_out_rs1_rnid[d]));
        check($sformatf("rs2 lane%0d", d), 32'(exp_rs2[d]), 32'(o_out_rs2_rnid[d]));
      end
    end
  endtask

  task automatic run_group(input lane_mask_t lv, input lane_mask_t rv,
                           input arch_reg_t rd0, input arch_reg_t rs1_0, input arch_reg_t rs2_0,
                           input arch_reg_t rd1, input arch_reg_t rs1_1, input arch_reg_t rs2_1);
    drive_group(lv, rv, rd0, rs1_0, rs2_0, rd1, rs1_1, rs2_1);
    predict_group();
    wait_strobe();
    check_group();
  endtask

  task automatic random_group(input lane_mask_t lv);
    run_group(lv, lv, pick_reg(), pick_reg(), pick_reg(), pick_reg(), pick_reg(), pick_reg());
  endtask

  // the push lands one edge after the registered strobe
  task automatic commit_one(input int lane, input logic dead, input arch_reg_t rd,
                            input rnid_t new_id, input rnid_t old_id);
    i_commit_valid          = 1'b1;
    i_commit_lane           = '0;
    i_commit_lane[lane]     = 1'b1;
    i_commit_dead           = '0;
    i_commit_dead[lane]     = dead;
    i_commit_rd_arch[lane]  = rd;
    i_commit_rd_rnid[lane]  = new_id;
    i_commit_old_rnid[lane] = old_id;
    if (rd != 0) begin
      release_id(lane, dead ? new_id : old_id);
    end
    @(negedge i_clk);
    i_commit_valid = 1'b0;
    i_commit_lane  = '0;
    @(negedge i_clk);
  endtask

  task automatic test_reset_identity();
    test_name = "reset identity";
    run_group(2'b01, 2'b01, 5, 3, 7, 0, 0, 0);
    check("rs1 identity", 32'd3, 32'(o_out_rs1_rnid[0]));
    check("rs2 identity", 32'd7, 32'(o_out_rs2_rnid[0]));
    check("first lane0 id", 32'd32, 32'(o_out_rd_rnid[0]));
    check("old identity", 32'd5, 32'(o_out_rd_old_rnid[0]));
  endtask

  task automatic test_forwarding();
    test_name = "in-group forwarding";
    run_group(2'b11, 2'b11, 10, 1, 2, 10, 10, 4);  // lane1 reads and rewrites x10
    check("lane0 new id", 32'd33, 32'(o_out_rd_rnid[0]));
    check("lane1 rs1 fwd", 32'd33, 32'(o_out_rs1_rnid[1]));
    check("lane1 old fwd", 32'd33, 32'(o_out_rd_old_rnid[1]));
    check("lane1 new id", 32'd48, 32'(o_out_rd_rnid[1]));
    run_group(2'b01, 2'b00, 0, 10, 0, 0, 0, 0);
    check("map holds lane1 id", 32'd48, 32'(o_out_rs1_rnid[0]));
  endtask

  task automatic test_x0_dest();
    test_name = "x0 destination";
    run_group(2'b01, 2'b01, 0, 0, 5, 0, 0, 0);
    check("x0 gets id 0", 32'd0, 32'(o_out_rd_rnid[0]));
    run_group(2'b01, 2'b01, 6, 0, 0, 0, 0, 0);
    check("no pop for x0", 32'd34, 32'(o_out_rd_rnid[0]));
    check("x0 still 0", 32'd0, 32'(o_out_rs1_rnid[0]));
  endtask

  task automatic test_stall_resource();
    test_name = "resource stall";
    i_resource_ok = 1'b0;
    drive_group(2'b01, 2'b01, 8, 10, 6, 0, 0, 0);
    predict_group();
    repeat (3) begin
      @(posedge i_clk);
      @(negedge i_clk);
      check("ready while blocked", 32'd0, 32'(o_in_ready));
      check("strobe while blocked", 32'd0, 32'(o_out_valid));
    end
    i_resource_ok = 1'b1;
    wait_strobe();
    check_group();
  endtask

  task automatic test_commit_release();
    int n;
    test_name = "commit release";
    commit_one(0, 1'b0, 5, 32, 5);    // normal commit gives old id 5 back to lane 0
    commit_one(1, 1'b1, 10, 48, 33);  // dead commit gives new id 48 back to lane 1
    n = free_q0.size();
    repeat (n) random_group(2'b01);
    check("old id reused last", 32'd5, 32'(o_out_rd_rnid[0]));
    last_old0 = exp_old[0];
    last_rd0  = i_in_rd_arch[0];
    n = free_q1.size();
    repeat (n) random_group(2'b10);
    check("dead id reused last", 32'd48, 32'(o_out_rd_rnid[1]));
  endtask

  task automatic test_stall_empty();
    test_name = "empty free list";
    drive_group(2'b01, 2'b01, 7, 1, 2, 0, 0, 0);
    @(posedge i_clk);
    @(negedge i_clk);
    check("ready with empty list", 32'd0, 32'(o_in_ready));
    check("no strobe", 32'd0, 32'(o_out_valid));
    i_in_valid = 1'b0;
    run_group(2'b11, 2'b00, 3, 4, 5, 6, 7, 8);  // fires since no lane needs a destination
    commit_one(0, 1'b0, last_rd0, 5, last_old0);
    run_group(2'b01, 2'b01, 7, 1, 2, 0, 0, 0);
    check("refilled id", 32'(last_old0), 32'(o_out_rd_rnid[0]));
  endtask

  initial begin
    i_clk             = 1'b0;
    i_reset_n         = 1'b0;
    i_in_valid        = 1'b0;
    i_in_lane_valid   = '0;
    i_in_rd_valid     = '0;
    i_in_rd_arch      = '0;
    i_in_rs1_arch     = '0;
    i_in_rs2_arch     = '0;
    i_resource_ok     = 1'b1;
    i_commit_valid    = 1'b0;
    i_commit_lane     = '0;
    i_commit_dead     = '0;
    i_commit_rd_arch  = '0;
    i_commit_rd_rnid  = '0;
    i_commit_old_rnid = '0;
    reset_model();
    repeat (RESET_CYC) @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);
    test_reset_identity();
    test_forwarding();
    test_x0_dest();
    test_stall_resource();
    test_commit_release();
    test_stall_empty();
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_cnt, other_cnt, rn_rename_top_i.rn_rename_asserts_i.fail_cnt);
    if ((mismatch_cnt == 0) && (other_cnt == 0) &&
        (rn_rename_top_i.rn_rename_asserts_i.fail_cnt == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rename
FLIST     := rn_rename_top.f
BUILD     := obj_dir
BIN       := $(BUILD)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BUILD)/V%: $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FLIST) --Mdir $(BUILD)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- rn_rename_top.f
common/rn_arch_pkg.sv
common/rn_phys_pkg.sv
common/rn_alloc_if.sv
common/rn_lookup_if.sv
rn_freelist_bank/rn_freelist.sv
rn_freelist_bank/rn_freelist_bank.sv
rn_map_table/rn_map_table.sv
src/rn_dispatch_merge.sv
src/rn_rename_top.sv
tb/rn_rename_asserts.sv
tb/tb_rename.sv
